//--- hw/ecc_mem_config.svh
`ifndef ECC_MEM_CONFIG_SVH
`define ECC_MEM_CONFIG_SVH

// --------------------
// Code geometry
// --------------------

// Payload bits of one stored word
`define ECC_DATA_WIDTH   67
// Check bits of the SECDED code over the payload
`define ECC_PARITY_WIDTH 8

// --------------------
// Storage and logging
// --------------------

`define MEM_DEPTH        64  // Words in the array, a power of two
`define ERR_COUNT_WIDTH  16  // Each error counter saturates at all ones

`endif

//--- hw/ecc_pkg.sv
`include "ecc_mem_config.svh"

package ecc_pkg;

    // --------------------
    // Codeword types
    // --------------------

    typedef logic [`ECC_DATA_WIDTH-1:0]   ecc_data_t;
    typedef logic [`ECC_PARITY_WIDTH-1:0] ecc_parity_t;

    // One stored word seen as a single vector
    typedef logic [`ECC_DATA_WIDTH+`ECC_PARITY_WIDTH-1:0] ecc_flat_t;

    typedef struct packed {
        ecc_parity_t parity;  // Check bits sit above the data
        ecc_data_t   data;
    } ecc_fields_t;

    // The encoder and decoder work on the fields, error injection on the flat word
    typedef union packed {
        ecc_fields_t f;
        ecc_flat_t   flat;
    } ecc_codeword_u;

    // --------------------
    // Check-bit encoding
    // --------------------

    // Each check bit is the XOR of its data column set. Bits 6:0 follow the Hamming
    // positions, bit 7 is the extra check that keeps single and double errors apart
    function automatic ecc_parity_t ecc_encode(input ecc_data_t d);
        ecc_parity_t p;
        p[0] = ^{d[65], d[63], d[61], d[59], d[57:56], d[54], d[52], d[50], d[48],
                 d[46], d[44], d[42], d[40], d[38], d[36], d[34], d[32], d[30],
                 d[28], d[26:25], d[23], d[21], d[19], d[17], d[15], d[13],
                 d[11:10], d[8], d[6], d[4:3], d[1:0]};
        p[1] = ^{d[66], d[63:62], d[59:58], d[56:55], d[52:51], d[48:47],
                 d[44:43], d[40:39], d[36:35], d[32:31], d[28:27], d[25:24],
                 d[21:20], d[17:16], d[13:12], d[10:9], d[6:5], d[3:2], d[0]};
        p[2] = ^{d[63:60], d[56:53], d[48:45], d[40:37], d[32:29], d[25:22],
                 d[17:14], d[10:7], d[3:1]};
        p[3] = ^{d[66:64], d[56:49], d[40:33], d[25:18], d[10:4]};
        p[4] = ^{d[56:41], d[25:11]};
        p[5] = ^d[56:26];
        p[6] = ^d[66:57];
        p[7] = ^{d[64:63], d[60], d[58:56], d[53], d[51:50], d[47:46], d[44],
                 d[41], d[39:38], d[36], d[33:32], d[29], d[27:26], d[24:23],
                 d[21], d[18:17], d[14], d[12:10], d[7], d[5:4], d[2:0]};
        return p;
    endfunction

endpackage

//--- hw/mem_pkg.sv
`include "ecc_mem_config.svh"

package mem_pkg;

    // Address wide enough for every word of the array
    typedef logic [$clog2(`MEM_DEPTH)-1:0] mem_addr_t;

    typedef logic [`ERR_COUNT_WIDTH-1:0] err_count_t;  // Saturating counter value

endpackage

//--- hw/ecc_67_secded.sv
`timescale 1ns/100ps

module ecc_67_secded
    import ecc_pkg::*;
(
    input  logic          bypass,
    input  ecc_codeword_u rd_word,
    output ecc_data_t     data_out,
    output ecc_data_t     mask,
    output logic          sbit_err,
    output logic          dbit_err
);

    ecc_parity_t syndrome;
    logic        data_hit;
    logic        parity_hit;
    logic [1:0]  error;  // Bit 0 single error, bit 1 double error

    // --------------------
    // Syndrome
    // --------------------

    assign syndrome = rd_word.f.parity ^ ecc_encode(rd_word.f.data);

    // A flipped data bit leaves exactly its own column pattern in the syndrome.
    // The column of bit i is the check word of a data word with only bit i set
    always_comb begin
        ecc_data_t unit;
        mask = '0;
        for (int i = 0; i < $bits(ecc_data_t); i++) begin
            unit = '0;
            unit[i] = 1'b1;
            if (syndrome == ecc_encode(unit)) begin
                mask[i] = 1'b1;
            end
        end
    end

    assign data_hit   = |mask;
    assign parity_hit = $onehot(syndrome);  // Only one check bit disagrees

    // --------------------
    // Classification
    // --------------------

    always_comb begin
        if (syndrome == '0) begin
            error = 2'b00;
        end else if (data_hit || parity_hit) begin
            error = 2'b01;  // Correctable, the mask is empty for a check bit
        end else begin
            error = 2'b10;
        end
    end

    // Bypass hands out the stored payload untouched
    assign data_out = bypass ? rd_word.f.data : rd_word.f.data ^ mask;
    assign sbit_err = bypass ? 1'b0 : error[0];
    assign dbit_err = bypass ? 1'b0 : error[1];

endmodule

//--- hw/ecc_mem_array.sv
`timescale 1ns/100ps
`include "ecc_mem_config.svh"

module ecc_mem_array
    import ecc_pkg::*, mem_pkg::*;
(
    input  logic          clk,
    input  logic          rst_n,
    input  logic          wr_en,
    input  mem_addr_t     wr_addr,
    input  ecc_data_t     wr_data,
    input  ecc_flat_t     inj_mask,
    input  logic          rd_en,
    input  mem_addr_t     rd_addr,
    output ecc_codeword_u rd_word,
    output logic          rd_valid,
    output mem_addr_t     rd_addr_q
);

    ecc_codeword_u enc_word;
    ecc_codeword_u wr_word;
    ecc_codeword_u mem [`MEM_DEPTH];

    // --------------------
    // Write path
    // --------------------

    always_comb begin
        enc_word.f.data   = wr_data;
        enc_word.f.parity = ecc_encode(wr_data);
        wr_word.flat      = enc_word.flat ^ inj_mask;  // Injected bits may land anywhere
    end

    always_ff @(posedge clk) begin
        if (wr_en) begin
            mem[wr_addr] <= wr_word;
        end
    end

    // --------------------
    // Read path
    // --------------------

    // Sampled before the write of the same edge lands, so a colliding read sees old data
    always_ff @(posedge clk) begin
        if (rd_en) begin
            rd_word   <= mem[rd_addr];
            rd_addr_q <= rd_addr;
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            rd_valid <= 1'b0;
        end else begin
            rd_valid <= rd_en;
        end
    end

endmodule

//--- hw/ecc_err_log.sv
`timescale 1ns/100ps

module ecc_err_log
    import mem_pkg::*;
(
    input  logic       clk,
    input  logic       rst_n,
    input  logic       rd_valid,
    input  mem_addr_t  rd_addr_q,
    input  logic       sbit_err,
    input  logic       dbit_err,
    input  logic       log_clear,
    output err_count_t sbit_count,
    output err_count_t dbit_count,
    output mem_addr_t  last_err_addr
);

    logic sbit_hit;
    logic dbit_hit;

    // The flags carry meaning only while a read result is on the bus
    assign sbit_hit = rd_valid && sbit_err;
    assign dbit_hit = rd_valid && dbit_err;

    // Counters stick at all ones instead of wrapping
    function automatic err_count_t sat_inc(input err_count_t count, input logic hit);
        if (hit && (count != '1)) begin
            return count + err_count_t'(1);
        end
        return count;
    endfunction

    // --------------------
    // Counters
    // --------------------

    always_ff @(posedge clk) begin
        if (!rst_n || log_clear) begin
            sbit_count <= '0;  // Clear wins over a hit in the same cycle
            dbit_count <= '0;
        end else begin
            sbit_count <= sat_inc(sbit_count, sbit_hit);
            dbit_count <= sat_inc(dbit_count, dbit_hit);
        end
    end

    // Address of the latest flagged read, kept across a counter clear
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            last_err_addr <= '0;
        end else if (sbit_hit || dbit_hit) begin
            last_err_addr <= rd_addr_q;
        end
    end

endmodule

//--- hw/ecc_mem_top.sv
`timescale 1ns/100ps

module ecc_mem_top
    import ecc_pkg::*, mem_pkg::*;
(
    input  logic       clk,
    input  logic       rst_n,
    // Write side
    input  logic       wr_en,
    input  mem_addr_t  wr_addr,
    input  ecc_data_t  wr_data,
    input  ecc_flat_t  inj_mask,
    // Read side
    input  logic       rd_en,
    input  mem_addr_t  rd_addr,
    input  logic       bypass,
    input  logic       log_clear,
    output logic       rd_valid,
    output ecc_data_t  rd_data,
    output logic       rd_sbit_err,
    output logic       rd_dbit_err,
    // Error log
    output err_count_t sbit_count,
    output err_count_t dbit_count,
    output mem_addr_t  last_err_addr
);

    ecc_codeword_u rd_word;
    mem_addr_t     rd_addr_q;  // Address of the word now on rd_word

    ecc_mem_array i_ecc_mem_array (
        .clk       (clk),
        .rst_n     (rst_n),
        .wr_en     (wr_en),
        .wr_addr   (wr_addr),
        .wr_data   (wr_data),
        .inj_mask  (inj_mask),
        .rd_en     (rd_en),
        .rd_addr   (rd_addr),
        .rd_word   (rd_word),
        .rd_valid  (rd_valid),
        .rd_addr_q (rd_addr_q)
    );

    // The correction mask stays internal to the decoder
    ecc_67_secded i_ecc_67_secded (
        .bypass   (bypass),
        .rd_word  (rd_word),
        .data_out (rd_data),
        .mask     (),
        .sbit_err (rd_sbit_err),
        .dbit_err (rd_dbit_err)
    );

    ecc_err_log i_ecc_err_log (
        .clk           (clk),
        .rst_n         (rst_n),
        .rd_valid      (rd_valid),
        .rd_addr_q     (rd_addr_q),
        .sbit_err      (rd_sbit_err),
        .dbit_err      (rd_dbit_err),
        .log_clear     (log_clear),
        .sbit_count    (sbit_count),
        .dbit_count    (dbit_count),
        .last_err_addr (last_err_addr)
    );

endmodule

//--- verification/tb_clk_gen.sv
`timescale 1ns/100ps

module tb_clk_gen #(
    parameter int PERIOD_NS    = 4,
    parameter int RESET_CYCLES = 3
) (
    output logic clk,
    output logic rst_n
);

    initial begin
        clk = 1'b0;
        forever #(PERIOD_NS / 2) clk = ~clk;
    end

    // Reset is released on a rising edge, like every other stimulus
    initial begin
        rst_n <= 1'b0;
        repeat (RESET_CYCLES) @(posedge clk);
        rst_n <= 1'b1;
    end

endmodule

//--- verification/ecc_mem_checker.sv
`timescale 1ns/100ps
`include "ecc_mem_config.svh"

module ecc_mem_checker
    import ecc_pkg::*, mem_pkg::*;
(
    input  logic       clk,
    input  logic       rst_n,
    input  logic       wr_en,
    input  mem_addr_t  wr_addr,
    input  ecc_data_t  wr_data,
    input  ecc_flat_t  inj_mask,
    input  logic       rd_en,
    input  mem_addr_t  rd_addr,
    input  logic       bypass,
    input  logic       log_clear,
    input  logic       rd_valid,
    input  ecc_data_t  rd_data,
    input  logic       rd_sbit_err,
    input  logic       rd_dbit_err,
    input  err_count_t sbit_count,
    input  err_count_t dbit_count,
    input  mem_addr_t  last_err_addr,
    output int         error_count,
    output int         read_count
);

    ecc_data_t  good_data [`MEM_DEPTH];  // Data as written
    ecc_data_t  raw_data  [`MEM_DEPTH];  // Payload as stored, injected data bits included
    int         flips     [`MEM_DEPTH];  // Bits flipped anywhere in the codeword

    // Read issued at the previous edge
    logic       pend_valid = 1'b0;
    mem_addr_t  pend_addr;
    ecc_data_t  pend_data;
    ecc_data_t  pend_raw;
    int         pend_flips;

    err_count_t model_sbit;
    err_count_t model_dbit;
    mem_addr_t  model_last;

    int errors = 0;
    int reads  = 0;

    assign error_count = errors;
    assign read_count  = reads;

    task automatic report_value(input string name, input ecc_flat_t got, input ecc_flat_t exp);
        $display("[FAIL] %s: got 0x%0h, expected 0x%0h at %0t", name, got, exp, $time);
        errors++;
    endtask

    // All inputs are sampled before the edge updates them
    always @(posedge clk) begin
        logic      exp_sbit;
        logic      exp_dbit;
        ecc_data_t exp_data;
        exp_sbit = 1'b0;
        exp_dbit = 1'b0;
        if (!rst_n) begin
            pend_valid = 1'b0;
            model_sbit = '0;
            model_dbit = '0;
            model_last = '0;
        end else begin
            // --------------------
            // Read result
            // --------------------
            if (rd_valid !== pend_valid) begin
                report_value("rd_valid", ecc_flat_t'(rd_valid), ecc_flat_t'(pend_valid));
            end
            if (pend_valid) begin
                exp_sbit = !bypass && (pend_flips == 1);
                exp_dbit = !bypass && (pend_flips == 2);
                exp_data = bypass ? pend_raw : pend_data;
                if (rd_sbit_err !== exp_sbit) begin
                    report_value("rd_sbit_err", ecc_flat_t'(rd_sbit_err), ecc_flat_t'(exp_sbit));
                end
                if (rd_dbit_err !== exp_dbit) begin
                    report_value("rd_dbit_err", ecc_flat_t'(rd_dbit_err), ecc_flat_t'(exp_dbit));
                end
                // A double error leaves the corrected data meaningless
                if ((bypass || pend_flips < 2) && (rd_data !== exp_data)) begin
                    report_value("rd_data", ecc_flat_t'(rd_data), ecc_flat_t'(exp_data));
                end
                reads++;
            end

            // --------------------
            // Error log
            // --------------------
            if (sbit_count !== model_sbit) begin
                report_value("sbit_count", ecc_flat_t'(sbit_count), ecc_flat_t'(model_sbit));
            end
            if (dbit_count !== model_dbit) begin
                report_value("dbit_count", ecc_flat_t'(dbit_count), ecc_flat_t'(model_dbit));
            end
            if (last_err_addr !== model_last) begin
                report_value("last_err_addr", ecc_flat_t'(last_err_addr),
                             ecc_flat_t'(model_last));
            end
            if (log_clear) begin
                model_sbit = '0;
                model_dbit = '0;
            end else begin
                if (exp_sbit && (model_sbit != '1)) model_sbit = model_sbit + err_count_t'(1);
                if (exp_dbit && (model_dbit != '1)) model_dbit = model_dbit + err_count_t'(1);
            end
            if (exp_sbit || exp_dbit) model_last = pend_addr;

            // Capture before the write so a colliding read sees the old word
            pend_valid = rd_en;
            if (rd_en) begin
                pend_addr  = rd_addr;
                pend_data  = good_data[rd_addr];
                pend_raw   = raw_data[rd_addr];
                pend_flips = flips[rd_addr];
            end
            if (wr_en) begin
                good_data[wr_addr] = wr_data;
                raw_data[wr_addr]  = wr_data ^ inj_mask[`ECC_DATA_WIDTH-1:0];
                flips[wr_addr]     = $countones(inj_mask);
            end
        end
    end

endmodule

//--- verification/ecc_mem_tb.sv
`timescale 1ns/100ps
`include "ecc_mem_config.svh"

module ecc_mem_tb
    import ecc_pkg::*, mem_pkg::*;
();

    localparam int CLK_PERIOD_NS = 4;
    localparam int ROUNDS        = 32;
    localparam int MIX_CYCLES    = 400;
    localparam int TEST_CYCLES   = 3 + 2 * `MEM_DEPTH + 7 * ROUNDS + MIX_CYCLES + 16;
    localparam int TIMEOUT_NS    = TEST_CYCLES * CLK_PERIOD_NS + 200;

    logic       clk;
    logic       rst_n;
    logic       wr_en;
    mem_addr_t  wr_addr;
    ecc_data_t  wr_data;
    ecc_flat_t  inj_mask;
    logic       rd_en;
    mem_addr_t  rd_addr;
    logic       bypass;
    logic       log_clear;
    logic       rd_valid;
    ecc_data_t  rd_data;
    logic       rd_sbit_err;
    logic       rd_dbit_err;
    err_count_t sbit_count;
    err_count_t dbit_count;
    mem_addr_t  last_err_addr;
    int         error_count;
    int         read_count;

    logic [31:0] lfsr = 32'h35f6_2b13;

    tb_clk_gen #(.PERIOD_NS(CLK_PERIOD_NS), .RESET_CYCLES(3)) i_tb_clk_gen (
        .clk   (clk),
        .rst_n (rst_n)
    );

    ecc_mem_top i_ecc_mem_top (
        .clk           (clk),
        .rst_n         (rst_n),
        .wr_en         (wr_en),
        .wr_addr       (wr_addr),
        .wr_data       (wr_data),
        .inj_mask      (inj_mask),
        .rd_en         (rd_en),
        .rd_addr       (rd_addr),
        .bypass        (bypass),
        .log_clear     (log_clear),
        .rd_valid      (rd_valid),
        .rd_data       (rd_data),
        .rd_sbit_err   (rd_sbit_err),
        .rd_dbit_err   (rd_dbit_err),
        .sbit_count    (sbit_count),
        .dbit_count    (dbit_count),
        .last_err_addr (last_err_addr)
    );

    ecc_mem_checker i_ecc_mem_checker (
        .clk           (clk),
        .rst_n         (rst_n),
        .wr_en         (wr_en),
        .wr_addr       (wr_addr),
        .wr_data       (wr_data),
        .inj_mask      (inj_mask),
        .rd_en         (rd_en),
        .rd_addr       (rd_addr),
        .bypass        (bypass),
        .log_clear     (log_clear),
        .rd_valid      (rd_valid),
        .rd_data       (rd_data),
        .rd_sbit_err   (rd_sbit_err),
        .rd_dbit_err   (rd_dbit_err),
        .sbit_count    (sbit_count),
        .dbit_count    (dbit_count),
        .last_err_addr (last_err_addr),
        .error_count   (error_count),
        .read_count    (read_count)
    );

    // --------------------
    // Random source
    // --------------------

    // Taps 32, 22, 2, 1
    function automatic logic [31:0] lfsr_step(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    task automatic take_bits(input int n, output ecc_flat_t v);
        v = '0;
        for (int i = 0; i < n; i++) begin
            lfsr = lfsr_step(lfsr);
            v = {v[$bits(ecc_flat_t)-2:0], lfsr[0]};
        end
    endtask

    task automatic rand_data(output ecc_data_t d);
        ecc_flat_t r;
        take_bits(`ECC_DATA_WIDTH, r);
        d = r[`ECC_DATA_WIDTH-1:0];
    endtask

    task automatic rand_addr(output mem_addr_t a);
        ecc_flat_t r;
        take_bits($bits(mem_addr_t), r);
        a = r[$bits(mem_addr_t)-1:0];
    endtask

    // Zero, one or two distinct flipped positions over the whole codeword
    task automatic make_mask(input int n_flips, output ecc_flat_t m);
        ecc_flat_t r;
        int        first;
        int        second;
        m = '0;
        take_bits(7, r);
        first = int'(r[6:0]) % $bits(ecc_flat_t);
        second = first;
        while (n_flips > 1 && second == first) begin
            take_bits(7, r);
            second = int'(r[6:0]) % $bits(ecc_flat_t);
        end
        if (n_flips > 0) m[first] = 1'b1;
        if (n_flips > 1) m[second] = 1'b1;
    endtask

    task automatic rand_flips(output int n_flips);
        ecc_flat_t r;
        take_bits(2, r);
        n_flips = (r[1:0] == 2'd3) ? 1 : int'(r[1:0]);
    endtask

    // --------------------
    // Bus cycles
    // --------------------

    task automatic drive(input logic we, input mem_addr_t wa, input ecc_data_t wd,
                         input ecc_flat_t im, input logic re, input mem_addr_t ra,
                         input logic bp, input logic clr);
        @(posedge clk);
        wr_en     <= we;
        wr_addr   <= wa;
        wr_data   <= wd;
        inj_mask  <= im;
        rd_en     <= re;
        rd_addr   <= ra;
        bypass    <= bp;
        log_clear <= clr;
    endtask

    task automatic write_word(input mem_addr_t a, input ecc_data_t d, input int n_flips);
        ecc_flat_t m;
        make_mask(n_flips, m);
        drive(1'b1, a, d, m, 1'b0, '0, 1'b0, 1'b0);
    endtask

    task automatic read_word(input mem_addr_t a, input logic bp);
        drive(1'b0, '0, '0, '0, 1'b1, a, bp, 1'b0);
    endtask

    task automatic idle();
        drive(1'b0, '0, '0, '0, 1'b0, '0, 1'b0, 1'b0);
    endtask

    initial begin
        ecc_data_t data;
        ecc_data_t old_data;
        ecc_flat_t r;
        ecc_flat_t m;
        mem_addr_t addr;
        mem_addr_t raddr;
        logic      we;
        logic      re;
        logic      bp;
        logic      clr;
        int        n_flips;
        wr_en     <= 1'b0;
        wr_addr   <= '0;
        wr_data   <= '0;
        inj_mask  <= '0;
        rd_en     <= 1'b0;
        rd_addr   <= '0;
        bypass    <= 1'b0;
        log_clear <= 1'b0;
        wait (rst_n);

        // Clean fill, then back-to-back reads of every word
        for (int a = 0; a < `MEM_DEPTH; a++) begin
            rand_data(data);
            write_word(mem_addr_t'(a), data, 0);
        end
        for (int a = 0; a < `MEM_DEPTH; a++) read_word(mem_addr_t'(a), 1'b0);

        // Single flips, then double flips
        for (int f = 1; f <= 2; f++) begin
            for (int i = 0; i < ROUNDS; i++) begin
                rand_addr(addr);
                rand_data(data);
                write_word(addr, data, f);
                read_word(addr, 1'b0);
            end
        end

        for (int i = 0; i < ROUNDS; i++) begin  // Raw view of corrupted words
            rand_addr(addr);
            rand_data(data);
            rand_flips(n_flips);
            write_word(addr, data, n_flips);
            read_word(addr, 1'b1);
            // Bypass acts in the cycle where the result is on the bus
            drive(1'b0, '0, '0, '0, 1'b0, '0, 1'b1, 1'b0);
        end

        // --------------------
        // Random mix
        // --------------------
        drive(1'b0, '0, '0, '0, 1'b0, '0, 1'b0, 1'b1);
        for (int i = 0; i < MIX_CYCLES; i++) begin
            take_bits(1, r);
            we = r[0];
            take_bits(1, r);
            re = r[0];
            take_bits(2, r);
            bp = (r[1:0] == 2'b00);
            take_bits(6, r);
            clr = (r[5:0] == 6'd0);  // Rare clears land among pending increments
            rand_flips(n_flips);
            make_mask(n_flips, m);
            rand_addr(addr);
            rand_addr(raddr);
            rand_data(data);
            drive(we, addr, data, m, re, raddr, bp, clr);
        end

        // Same-cycle read and write of one word
        rand_addr(addr);
        rand_data(old_data);
        write_word(addr, old_data, 0);
        rand_data(data);
        drive(1'b1, addr, data, '0, 1'b1, addr, 1'b0, 1'b0);
        read_word(addr, 1'b0);

        drive(1'b0, '0, '0, '0, 1'b0, '0, 1'b0, 1'b1);
        repeat (3) idle();
        @(negedge clk);  // The checker is done with the last edge

        if (read_count == 0) $display("No read result reached the checker");
        $display("Checks done: %0d reads compared, %0d errors", read_count, error_count);
        if (error_count == 0 && read_count > 0) begin
            $display("Simulation finished: PASS");
        end else begin
            $display("Simulation finished: FAIL");
        end
        $finish;
    end

    initial begin
        #(TIMEOUT_NS);
        $display("Watchdog expired after %0d ns before the test sequence ended", TIMEOUT_NS);
        $display("Simulation finished: FAIL");
        $finish;
    end

endmodule

//--- project.f
+incdir+hw
hw/ecc_pkg.sv
hw/mem_pkg.sv
hw/ecc_67_secded.sv
hw/ecc_mem_array.sv
hw/ecc_err_log.sv
hw/ecc_mem_top.sv
verification/tb_clk_gen.sv
verification/ecc_mem_checker.sv
verification/ecc_mem_tb.sv

//--- Makefile
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing -j 0
TOP       := ecc_mem_tb
FILELIST  := project.f

BUILD_DIR := obj_dir
SIM_BIN   := $(BUILD_DIR)/V$(TOP)
LOG       := sim.log
PASS_MSG  := Simulation finished: PASS

SOURCES   := $(shell grep -v '^+' $(FILELIST)) $(wildcard hw/*.svh)

.PHONY: all build run clean

all: run

build: $(SIM_BIN)

# Rebuilt only when a source or the file list changes
$(SIM_BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR) -o V$(TOP)

run: $(SIM_BIN)
	./$(SIM_BIN) | tee $(LOG)
	@grep -qx "$(PASS_MSG)" $(LOG) || { echo "Pass message not found in $(LOG)"; exit 1; }

clean:
	rm -rf $(BUILD_DIR) $(LOG)
